/* design/acc_csr_pkg.sv */
`default_nettype none

package acc_csr_pkg;

  // ----------------------------------------
  // Widths with a meaning
  // ----------------------------------------
  // CSR value, operand or engine result
  typedef logic [31:0] csr_data_t;
  // CSR address as issued by the core
  typedef logic [31:0] csr_addr_t;
  // Register index inside the CSR map
  typedef logic [2:0]  csr_idx_t;
  // Raw instruction word on the offload port
  typedef logic [31:0] instr_t;
  // Transaction id for response routing
  typedef logic [4:0]  acc_id_t;

  // ----------------------------------------
  // CSR map
  // ----------------------------------------
  localparam csr_idx_t CsrOpA     = 3'd0;
  localparam csr_idx_t CsrOpB     = 3'd1;
  localparam csr_idx_t CsrCount   = 3'd2;
  // Bit 0 set on write starts the engine
  localparam csr_idx_t CsrCtrl    = 3'd3;
  // Bit 0 is busy, read-only
  localparam csr_idx_t CsrStatus  = 3'd4;
  // Read-only, loaded when the engine finishes
  localparam csr_idx_t CsrResult  = 3'd5;
  // First index outside the map
  localparam csr_idx_t CsrNumRegs = 3'd6;

  // ----------------------------------------
  // Instruction match patterns
  // ----------------------------------------
  // Fixed funct3 and SYSTEM opcode, rest don't-care
  localparam instr_t CsrrsMatch  = 32'b????????????_?????_010_?????_1110011;
  localparam instr_t CsrrcMatch  = 32'b????????????_?????_011_?????_1110011;
  localparam instr_t CsrrsiMatch = 32'b????????????_?????_110_?????_1110011;
  localparam instr_t CsrrciMatch = 32'b????????????_?????_111_?????_1110011;

endpackage

`default_nettype wire

/* design/acc_id_fifo.sv */
`default_nettype none

module acc_id_fifo #(
  parameter int unsigned Depth = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  // Write side
  input  wire logic                push_i,
  input  wire acc_csr_pkg::acc_id_t push_id_i,
  // Read side
  input  wire logic                pop_i,
  output acc_csr_pkg::acc_id_t     head_id_o,
  // Occupancy flags
  output logic                     full_o,
  output logic                     empty_o
);

  // Pointer and counter widths
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  acc_csr_pkg::acc_id_t mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  // Flags straight from the count
  assign full_o    = (count_q == CntW'(Depth));
  assign empty_o   = (count_q == '0);
  // Oldest outstanding id
  assign head_id_o = mem_q[rd_ptr_q];

  // Id storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_id_i;
    end
  end

  // Pointers wrap at Depth even when it is not a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/acc_intf_translator.sv */
`default_nettype none

module acc_intf_translator #(
  // Base address of the CSR block in the core's CSR space
  parameter acc_csr_pkg::csr_addr_t CsrAddrOffset = 32'h3c0,
  parameter int unsigned            IdFifoDepth   = 4
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // Core request side
  input  wire acc_csr_pkg::instr_t    acc_req_op_i,
  input  wire acc_csr_pkg::csr_data_t acc_req_arga_i,
  input  wire acc_csr_pkg::csr_addr_t acc_req_argb_i,
  input  wire acc_csr_pkg::acc_id_t   acc_req_id_i,
  input  wire logic                   acc_qvalid_i,
  output logic                        acc_qready_o,
  // Core response side
  output acc_csr_pkg::csr_data_t      acc_rsp_data_o,
  output acc_csr_pkg::acc_id_t        acc_rsp_id_o,
  output logic                        acc_rsp_error_o,
  output logic                        acc_pvalid_o,
  input  wire logic                   acc_pready_i,
  // CSR request side
  output acc_csr_pkg::csr_data_t      csr_req_data_o,
  output acc_csr_pkg::csr_idx_t       csr_req_addr_o,
  output logic                        csr_req_write_o,
  output logic                        csr_req_valid_o,
  input  wire logic                   csr_req_ready_i,
  // CSR response side
  input  wire acc_csr_pkg::csr_data_t csr_rsp_data_i,
  input  wire logic                   csr_rsp_error_i,
  input  wire logic                   csr_rsp_valid_i,
  output logic                        csr_rsp_ready_o
);

  logic                   write_csr;
  acc_csr_pkg::csr_addr_t addr_rebased;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   id_push;
  logic                   id_pop;

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  // Set and clear forms act as reads, all else writes
  always_comb begin
    unique casez (acc_req_op_i)
      acc_csr_pkg::CsrrsMatch,
      acc_csr_pkg::CsrrsiMatch,
      acc_csr_pkg::CsrrcMatch,
      acc_csr_pkg::CsrrciMatch: write_csr = 1'b0;
      default:                  write_csr = 1'b1;
    endcase
  end

  // Rebase into the map, park anything outside at index 7
  assign addr_rebased = acc_req_argb_i - CsrAddrOffset;
  always_comb begin
    if (addr_rebased >= acc_csr_pkg::csr_addr_t'(acc_csr_pkg::CsrNumRegs)) begin
      csr_req_addr_o = 3'd7;
    end else begin
      csr_req_addr_o = addr_rebased[2:0];
    end
  end

  assign csr_req_data_o  = acc_req_arga_i;
  assign csr_req_write_o = write_csr;
  // No new request without room for its id
  assign csr_req_valid_o = acc_qvalid_i && !fifo_full;
  assign acc_qready_o    = csr_req_ready_i && !fifo_full;
  assign id_push         = acc_qvalid_i && acc_qready_o;

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  assign acc_pvalid_o    = csr_rsp_valid_i;
  assign csr_rsp_ready_o = acc_pready_i;
  assign acc_rsp_data_o  = csr_rsp_data_i;
  assign acc_rsp_error_o = csr_rsp_error_i;
  // Retire the oldest id with its response
  assign id_pop          = csr_rsp_valid_i && acc_pready_i && !fifo_empty;

  // Ids of outstanding requests, oldest at the head
  acc_id_fifo #(
    .Depth (IdFifoDepth)
  ) i_acc_id_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .push_i    (id_push),
    .push_id_i (acc_req_id_i),
    .pop_i     (id_pop),
    .head_id_o (acc_rsp_id_o),
    .full_o    (fifo_full),
    .empty_o   (fifo_empty)
  );

endmodule

`default_nettype wire

/* design/acc_csr_file.sv */
`default_nettype none

module acc_csr_file (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // CSR request
  input  wire acc_csr_pkg::csr_data_t csr_req_data_i,
  input  wire acc_csr_pkg::csr_idx_t  csr_req_addr_i,
  input  wire logic                   csr_req_write_i,
  input  wire logic                   csr_req_valid_i,
  output logic                        csr_req_ready_o,
  // CSR response
  output acc_csr_pkg::csr_data_t      csr_rsp_data_o,
  output logic                        csr_rsp_error_o,
  output logic                        csr_rsp_valid_o,
  input  wire logic                   csr_rsp_ready_i,
  // Engine control
  output logic                        eng_start_o,
  output acc_csr_pkg::csr_data_t      eng_opa_o,
  output acc_csr_pkg::csr_data_t      eng_opb_o,
  output acc_csr_pkg::csr_data_t      eng_count_o,
  // Engine status
  input  wire logic                   eng_busy_i,
  input  wire logic                   eng_done_i,
  input  wire acc_csr_pkg::csr_data_t eng_result_i
);

  acc_csr_pkg::csr_data_t opa_q;
  acc_csr_pkg::csr_data_t opb_q;
  acc_csr_pkg::csr_data_t count_q;
  acc_csr_pkg::csr_data_t result_q;
  // One-entry response stage
  logic                   rsp_valid_q;
  acc_csr_pkg::csr_data_t rsp_data_q;
  logic                   rsp_error_q;
  // Decoded request
  logic                   req_accept;
  logic                   req_error;
  logic                   req_wr;
  acc_csr_pkg::csr_data_t rd_data;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  // Free stage, or one draining this cycle
  assign csr_req_ready_o = !rsp_valid_q || csr_rsp_ready_i;
  assign req_accept      = csr_req_valid_i && csr_req_ready_o;
  assign req_error       = (csr_req_addr_i >= acc_csr_pkg::CsrNumRegs);
  assign req_wr          = req_accept && csr_req_write_i && !req_error;

  // Read mux, also the old value returned by a write
  always_comb begin
    unique case (csr_req_addr_i)
      acc_csr_pkg::CsrOpA:    rd_data = opa_q;
      acc_csr_pkg::CsrOpB:    rd_data = opb_q;
      acc_csr_pkg::CsrCount:  rd_data = count_q;
      // CTRL is write-only
      acc_csr_pkg::CsrCtrl:   rd_data = '0;
      acc_csr_pkg::CsrStatus: rd_data = {31'b0, eng_busy_i};
      acc_csr_pkg::CsrResult: rd_data = result_q;
      default:                rd_data = '0;
    endcase
  end

  // Start only from idle, a start while busy is dropped
  assign eng_start_o = req_wr && (csr_req_addr_i == acc_csr_pkg::CsrCtrl)
                       && csr_req_data_i[0] && !eng_busy_i;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      opa_q    <= '0;
      opb_q    <= '0;
      count_q  <= '0;
      result_q <= '0;
    end else begin
      if (req_wr) begin
        // STATUS and RESULT writes fall through
        unique case (csr_req_addr_i)
          acc_csr_pkg::CsrOpA:   opa_q   <= csr_req_data_i;
          acc_csr_pkg::CsrOpB:   opb_q   <= csr_req_data_i;
          acc_csr_pkg::CsrCount: count_q <= csr_req_data_i;
          default: ;
        endcase
      end
      // Engine owns RESULT
      if (eng_done_i) begin
        result_q <= eng_result_i;
      end
    end
  end

  // Response stage, held while stalled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_data_q  <= '0;
      rsp_error_q <= 1'b0;
    end else if (req_accept) begin
      rsp_valid_q <= 1'b1;
      rsp_data_q  <= req_error ? '0 : rd_data;
      rsp_error_q <= req_error;
    end else if (csr_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rsp_data_o  = rsp_data_q;
  assign csr_rsp_error_o = rsp_error_q;

  // Operands straight from the map
  assign eng_opa_o   = opa_q;
  assign eng_opb_o   = opb_q;
  assign eng_count_o = count_q;

endmodule

`default_nettype wire

/* design/acc_mac_engine.sv */
`default_nettype none

module acc_mac_engine (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // Start and operands from the CSR file
  input  wire logic                   start_i,
  input  wire acc_csr_pkg::csr_data_t opa_i,
  input  wire acc_csr_pkg::csr_data_t opb_i,
  input  wire acc_csr_pkg::csr_data_t count_i,
  // Status back to the CSR file
  output logic                        busy_o,
  output logic                        done_o,
  output acc_csr_pkg::csr_data_t      result_o
);

  typedef enum logic {
    StIdle,
    StRun
  } state_e;

  state_e                 state_q;
  acc_csr_pkg::csr_data_t opa_q;
  acc_csr_pkg::csr_data_t opb_q;
  // Cycles left including the current one
  acc_csr_pkg::csr_data_t remain_q;
  acc_csr_pkg::csr_data_t acc_q;
  acc_csr_pkg::csr_data_t product;

  // Low 32 bits only
  assign product  = opa_q * opb_q;
  // Sum after this cycle's step
  assign result_o = acc_q + product;
  assign busy_o   = (state_q == StRun);
  // Last iteration
  assign done_o   = busy_o && (remain_q == 32'd1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= StIdle;
      opa_q    <= '0;
      opb_q    <= '0;
      remain_q <= '0;
      acc_q    <= '0;
    end else begin
      unique case (state_q)
        StIdle: begin
          if (start_i) begin
            state_q  <= StRun;
            opa_q    <= opa_i;
            // Zero count runs one cycle adding nothing
            opb_q    <= (count_i == '0) ? '0 : opb_i;
            remain_q <= (count_i == '0) ? 32'd1 : count_i;
            acc_q    <= '0;
          end
        end
        StRun: begin
          acc_q    <= result_o;
          remain_q <= remain_q - 32'd1;
          if (done_o) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/acc_subsystem_top.sv */
`default_nettype none

module acc_subsystem_top #(
  parameter acc_csr_pkg::csr_addr_t CsrAddrOffset = 32'h3c0,
  parameter int unsigned            IdFifoDepth   = 4
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // Offload request from the core
  input  wire acc_csr_pkg::instr_t    acc_req_op_i,
  input  wire acc_csr_pkg::csr_data_t acc_req_arga_i,
  input  wire acc_csr_pkg::csr_addr_t acc_req_argb_i,
  input  wire acc_csr_pkg::acc_id_t   acc_req_id_i,
  input  wire logic                   acc_qvalid_i,
  output logic                        acc_qready_o,
  // Offload response to the core
  output acc_csr_pkg::csr_data_t      acc_rsp_data_o,
  output acc_csr_pkg::acc_id_t        acc_rsp_id_o,
  output logic                        acc_rsp_error_o,
  output logic                        acc_pvalid_o,
  input  wire logic                   acc_pready_i
);

  // ----------------------------------------
  // Translator to CSR file
  // ----------------------------------------
  acc_csr_pkg::csr_data_t csr_req_data;
  acc_csr_pkg::csr_idx_t  csr_req_addr;
  logic                   csr_req_write;
  logic                   csr_req_valid;
  logic                   csr_req_ready;
  acc_csr_pkg::csr_data_t csr_rsp_data;
  logic                   csr_rsp_error;
  logic                   csr_rsp_valid;
  logic                   csr_rsp_ready;

  // CSR file to engine
  logic                   eng_start;
  acc_csr_pkg::csr_data_t eng_opa;
  acc_csr_pkg::csr_data_t eng_opb;
  acc_csr_pkg::csr_data_t eng_count;
  logic                   eng_busy;
  logic                   eng_done;
  acc_csr_pkg::csr_data_t eng_result;

  acc_intf_translator #(
    .CsrAddrOffset (CsrAddrOffset),
    .IdFifoDepth   (IdFifoDepth)
  ) i_acc_intf_translator (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .acc_req_op_i    (acc_req_op_i),
    .acc_req_arga_i  (acc_req_arga_i),
    .acc_req_argb_i  (acc_req_argb_i),
    .acc_req_id_i    (acc_req_id_i),
    .acc_qvalid_i    (acc_qvalid_i),
    .acc_qready_o    (acc_qready_o),
    .acc_rsp_data_o  (acc_rsp_data_o),
    .acc_rsp_id_o    (acc_rsp_id_o),
    .acc_rsp_error_o (acc_rsp_error_o),
    .acc_pvalid_o    (acc_pvalid_o),
    .acc_pready_i    (acc_pready_i),
    .csr_req_data_o  (csr_req_data),
    .csr_req_addr_o  (csr_req_addr),
    .csr_req_write_o (csr_req_write),
    .csr_req_valid_o (csr_req_valid),
    .csr_req_ready_i (csr_req_ready),
    .csr_rsp_data_i  (csr_rsp_data),
    .csr_rsp_error_i (csr_rsp_error),
    .csr_rsp_valid_i (csr_rsp_valid),
    .csr_rsp_ready_o (csr_rsp_ready)
  );

  acc_csr_file i_acc_csr_file (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .csr_req_data_i  (csr_req_data),
    .csr_req_addr_i  (csr_req_addr),
    .csr_req_write_i (csr_req_write),
    .csr_req_valid_i (csr_req_valid),
    .csr_req_ready_o (csr_req_ready),
    .csr_rsp_data_o  (csr_rsp_data),
    .csr_rsp_error_o (csr_rsp_error),
    .csr_rsp_valid_o (csr_rsp_valid),
    .csr_rsp_ready_i (csr_rsp_ready),
    .eng_start_o     (eng_start),
    .eng_opa_o       (eng_opa),
    .eng_opb_o       (eng_opb),
    .eng_count_o     (eng_count),
    .eng_busy_i      (eng_busy),
    .eng_done_i      (eng_done),
    .eng_result_i    (eng_result)
  );

  acc_mac_engine i_acc_mac_engine (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (eng_start),
    .opa_i    (eng_opa),
    .opb_i    (eng_opb),
    .count_i  (eng_count),
    .busy_o   (eng_busy),
    .done_o   (eng_done),
    .result_o (eng_result)
  );

endmodule

`default_nettype wire

/* bench/tb_acc_subsystem.sv */
`default_nettype none

module tb_acc_subsystem;

  // ----------------------------------------
  // Timing and stimulus layout
  // ----------------------------------------
  localparam int          HalfPeriod    = 10;
  // Sample point between the falling and the rising edge
  localparam int          QuarterPeriod = 5;
  localparam int          FieldsPerRow  = 7;
  localparam int          MaxRows       = 64;
  localparam int          QuietCycles   = 8;
  localparam logic [31:0] RandomSeed    = 32'h1e22_3c87;

  logic                   clk_i;
  logic                   rst_i;
  acc_csr_pkg::instr_t    acc_req_op_i;
  acc_csr_pkg::csr_data_t acc_req_arga_i;
  acc_csr_pkg::csr_addr_t acc_req_argb_i;
  acc_csr_pkg::acc_id_t   acc_req_id_i;
  logic                   acc_qvalid_i;
  logic                   acc_qready_o;
  acc_csr_pkg::csr_data_t acc_rsp_data_o;
  acc_csr_pkg::acc_id_t   acc_rsp_id_o;
  logic                   acc_rsp_error_o;
  logic                   acc_pvalid_o;
  logic                   acc_pready_i;

  // Table columns are test, instr, arga, argb, id, exp data, exp error
  logic [31:0] stim_mem [MaxRows*FieldsPerRow];
  int          num_rows;
  int          rsp_count;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  int          cycle_limit = 1000;
  // Per test bookkeeping indexed by test number
  int          test_last_row [8];
  int          test_errors [8];
  int          test_rows [8];

  acc_subsystem_top #(
    .CsrAddrOffset (32'h3c0),
    .IdFifoDepth   (4)
  ) i_acc_subsystem_top (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .acc_req_op_i    (acc_req_op_i),
    .acc_req_arga_i  (acc_req_arga_i),
    .acc_req_argb_i  (acc_req_argb_i),
    .acc_req_id_i    (acc_req_id_i),
    .acc_qvalid_i    (acc_qvalid_i),
    .acc_qready_o    (acc_qready_o),
    .acc_rsp_data_o  (acc_rsp_data_o),
    .acc_rsp_id_o    (acc_rsp_id_o),
    .acc_rsp_error_o (acc_rsp_error_o),
    .acc_pvalid_o    (acc_pvalid_o),
    .acc_pready_i    (acc_pready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(HalfPeriod) clk_i = ~clk_i;
  end

  // Run limit from the table length
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: no end of test after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_stimulus();
    for (int i = 0; i < MaxRows * FieldsPerRow; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("bench/acc_stimulus.txt", stim_mem);
    // Test number 0 marks the end of the table
    num_rows = 0;
    while (num_rows < MaxRows && stim_mem[num_rows * FieldsPerRow] != 0) begin
      test_last_row[stim_mem[num_rows * FieldsPerRow][2:0]] = num_rows;
      num_rows++;
    end
  endtask

  task automatic check_value(input int test_num, input int row, input string what,
                             input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) begin
      pass_count++;
    end else begin
      $display("CHECK FAILED at %0t: row %0d %s is %h, expected %h",
               $time, row, what, got, exp);
      fail_count++;
      test_errors[test_num]++;
    end
  endtask

  // Compare the response on the port with its table row
  task automatic check_response(input int row);
    int base;
    int test_num;
    base     = row * FieldsPerRow;
    test_num = int'(stim_mem[base][2:0]);
    check_value(test_num, row, "data", acc_rsp_data_o, stim_mem[base + 5]);
    check_value(test_num, row, "id", {27'b0, acc_rsp_id_o},
                {27'b0, stim_mem[base + 4][4:0]});
    check_value(test_num, row, "error", {31'b0, acc_rsp_error_o},
                {31'b0, stim_mem[base + 6][0]});
    test_rows[test_num]++;
    if (row == test_last_row[test_num]) begin
      $display("Test %0d finished: %0d responses, %0d failed checks",
               test_num, test_rows[test_num], test_errors[test_num]);
    end
  endtask

  // Each row held until the DUT takes it
  task automatic drive_requests();
    int row;
    int base;
    row = 0;
    while (row < num_rows) begin
      @(negedge clk_i);
      base           = row * FieldsPerRow;
      acc_req_op_i   = stim_mem[base + 1];
      acc_req_arga_i = stim_mem[base + 2];
      acc_req_argb_i = stim_mem[base + 3];
      acc_req_id_i   = stim_mem[base + 4][4:0];
      acc_qvalid_i   = 1'b1;
      #(QuarterPeriod);
      if (acc_qready_o) begin
        row++;
      end
    end
    @(negedge clk_i);
    acc_qvalid_i = 1'b0;
  endtask

  // Back-pressure about one cycle in four
  // Responses checked in order
  task automatic watch_responses();
    logic [31:0] rnd;
    rnd = RandomSeed;
    while (rsp_count < num_rows) begin
      @(negedge clk_i);
      rnd          = xorshift32(rnd);
      acc_pready_i = (rnd[1:0] != 2'b00);
      #(QuarterPeriod);
      // A stalled response blocks new requests
      if (acc_pvalid_o && !acc_pready_i) begin
        assert (!acc_qready_o) begin
          pass_count++;
        end else begin
          $display("CHECK FAILED at %0t: qready high while response %0d is stalled",
                   $time, rsp_count);
          fail_count++;
        end
      end
      if (acc_pvalid_o && acc_pready_i) begin
        check_response(rsp_count);
        rsp_count++;
      end
    end
    @(negedge clk_i);
    acc_pready_i = 1'b1;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_i          = 1'b1;
    acc_req_op_i   = '0;
    acc_req_arga_i = '0;
    acc_req_argb_i = '0;
    acc_req_id_i   = '0;
    acc_qvalid_i   = 1'b0;
    acc_pready_i   = 1'b1;
    rsp_count      = 0;
    pass_count     = 0;
    fail_count     = 0;
    cycle_count    = 0;
    for (int t = 0; t < 8; t++) begin
      test_last_row[t] = -1;
      test_errors[t]   = 0;
      test_rows[t]     = 0;
    end
    load_stimulus();
    cycle_limit = 64 * num_rows + 1000;
    assert (num_rows > 0) else begin
      $display("Stimulus file holds no request rows");
      fail_count++;
    end

    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    fork
      drive_requests();
      watch_responses();
    join

    // Nothing may follow the last expected response
    repeat (QuietCycles) begin
      @(negedge clk_i);
      #(QuarterPeriod);
      assert (!acc_pvalid_o) else begin
        $display("Extra response at %0t with id %h beyond the last request",
                 $time, acc_rsp_id_o);
        fail_count++;
      end
    end

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/acc_stimulus.txt */
// test instr arga argb id exp_data exp_err, all hex, one request per row
// Expected columns give the response of that request, in request order
1 3c0110f3 00000011 000003c0 01 00000000 0
1 3c0110f3 00010003 000003c0 02 00000011 0
1 3c1110f3 00020005 000003c1 03 00000000 0
1 3c2110f3 00000007 000003c2 04 00000000 0
1 3c0020f3 00000000 000003c0 05 00010003 0
1 3c1020f3 00000000 000003c1 06 00020005 0
1 3c2020f3 00000000 000003c2 07 00000007 0
3 3c3110f3 00000001 000003c3 08 00000000 0
2 3c01b0f3 ffffffff 000003c0 09 00010003 0
2 3c11a0f3 ffffffff 000003c1 0a 00020005 0
2 3c0060f3 00000000 000003c0 0b 00010003 0
2 3c1070f3 00000000 000003c1 0c 00020005 0
5 3c6020f3 00000000 000003c6 0d 00000000 1
5 3c7110f3 12345678 000003c7 0e 00000000 1
5 3bf020f3 00000000 000003bf 0f 00000000 1
3 3c4020f3 00000000 000003c4 10 00000000 0
3 3c5020f3 00000000 000003c5 11 004d0069 0
5 3c5110f3 deadbeef 000003c5 12 004d0069 0
5 3c5020f3 00000000 000003c5 13 004d0069 0
3 3c2110f3 00000001 000003c2 14 00000007 0
3 3c3110f3 00000001 000003c3 15 00000000 0
3 3c0020f3 00000000 000003c0 16 00010003 0
3 3c4020f3 00000000 000003c4 17 00000000 0
3 3c5020f3 00000000 000003c5 18 000b000f 0
3 3c2110f3 00000000 000003c2 19 00000001 0
3 3c3110f3 00000001 000003c3 1a 00000000 0
3 3c1020f3 00000000 000003c1 1b 00020005 0
3 3c4020f3 00000000 000003c4 1c 00000000 0
3 3c5020f3 00000000 000003c5 1d 00000000 0
4 3c2110f3 0000000a 000003c2 1e 00000000 0
4 3c3110f3 00000001 000003c3 1f 00000000 0
4 3c0110f3 00000002 000003c0 00 00010003 0
4 3c3110f3 00000001 000003c3 01 00000000 0
6 3c0020f3 00000000 000003c0 15 00000002 0
6 3c1020f3 00000000 000003c1 03 00020005 0
6 3c2020f3 00000000 000003c2 1c 0000000a 0
6 3c3020f3 00000000 000003c3 07 00000000 0
6 7c0020f3 00000000 000007c0 1a 00000000 1
6 3c0060f3 00000000 000003c0 0b 00000002 0
6 3c1070f3 00000000 000003c1 11 00020005 0
6 3c2020f3 00000000 000003c2 1f 0000000a 0
4 3c4020f3 00000000 000003c4 09 00000000 0
4 3c5020f3 00000000 000003c5 0e 006e0096 0

/* tb.f */
design/acc_csr_pkg.sv
design/acc_id_fifo.sv
design/acc_intf_translator.sv
design/acc_csr_file.sv
design/acc_mac_engine.sv
design/acc_subsystem_top.sv
bench/tb_acc_subsystem.sv

/* Makefile */
# Tool, flags, top module and file list
VERILATOR  ?= verilator
TOP        := tb_acc_subsystem
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# Static checks of RTL and testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, pass only if the pass line shows up
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
